//--- common/exu_pkg.sv
// Shared widths, opcodes and bundle types of the integer execution stage
`default_nettype none

package exu_pkg;

  localparam int XLEN       = 32;
  localparam int RFIDX_W    = 5;
  localparam int OITF_DEPTH = 2;                    // Loads in flight
  localparam int ITAG_W     = $clog2(OITF_DEPTH);

  // Major opcodes of the kept subset
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT,
    ALU_PASSB                                       // Operand 2 through, for LUI
  } alu_op_e;

  typedef struct packed {
    logic [RFIDX_W-1:0] rs1idx;
    logic [RFIDX_W-1:0] rs2idx;
    logic [RFIDX_W-1:0] rdidx;
    logic               rs1en;
    logic               rs2en;
    logic               rdwen;
    logic               imm_sel;                    // Operand 2 from immediate
    logic               is_load;
    logic               illegal;
    alu_op_e            alu_op;
  } dec_info_t;

  typedef struct packed {
    logic [XLEN-1:0]    op1;
    logic [XLEN-1:0]    op2;
    logic [RFIDX_W-1:0] rdidx;
    logic               rdwen;
    logic               is_load;
    alu_op_e            alu_op;
  } alu_req_t;

  typedef struct packed {
    logic               vld;
    logic [RFIDX_W-1:0] rdidx;
    logic [XLEN-1:0]    data;
  } wbck_t;

  typedef struct packed {
    logic [RFIDX_W-1:0] rdidx;
    logic [XLEN-1:0]    addr;
  } oitf_entry_t;

  // Wishbone classic, read-only master side
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic [XLEN-1:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- source/exu_regfile.sv
// Integer register file, x1..x31 with two read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module exu_regfile import exu_pkg::*; (
  input  wire logic               clk,
  input  wire logic               i_arst_n,
  input  wire logic [RFIDX_W-1:0] i_rs1idx,
  input  wire logic [RFIDX_W-1:0] i_rs2idx,
  output      logic [XLEN-1:0]    o_rs1,
  output      logic [XLEN-1:0]    o_rs2,
  input  wire wbck_t              i_wbck,
  output      logic [XLEN-1:0]    o_x1
);

  logic [XLEN-1:0] rf_q [1:31];                     // No storage for x0

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wbck.vld && (i_wbck.rdidx != '0)) begin
      rf_q[i_wbck.rdidx] <= i_wbck.data;
    end
  end

  // Reads see the value before a same-cycle write
  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];
  assign o_x1  = rf_q[1];                           // Read-out for the fetch side

endmodule

`default_nettype wire

//--- source/exu_decode.sv
// Instruction decoder for the integer subset, with immediate and illegal flag
`timescale 1ns/1ps
`default_nettype none

module exu_decode import exu_pkg::*; (
  input  wire logic [XLEN-1:0] i_ir,
  output      dec_info_t       o_dec,
  output      logic [XLEN-1:0] o_imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_ir[6:0];
  assign funct3 = i_ir[14:12];
  assign funct7 = i_ir[31:25];

  always_comb begin
    o_dec         = '0;
    o_dec.rs1idx  = i_ir[19:15];
    o_dec.rs2idx  = i_ir[24:20];
    o_dec.rdidx   = i_ir[11:7];
    o_dec.alu_op  = ALU_ADD;
    o_dec.illegal = 1'b1;                           // Cleared by a known encoding
    case (opcode)
      OPC_OP: begin
        o_dec.rs1en = 1'b1;
        o_dec.rs2en = 1'b1;
        o_dec.rdwen = 1'b1;
        if (funct7 == 7'b0000000) begin
          o_dec.illegal = 1'b0;
          case (funct3)
            3'b000:  o_dec.alu_op = ALU_ADD;
            3'b001:  o_dec.alu_op = ALU_SLL;
            3'b010:  o_dec.alu_op = ALU_SLT;
            3'b100:  o_dec.alu_op = ALU_XOR;
            3'b101:  o_dec.alu_op = ALU_SRL;
            3'b110:  o_dec.alu_op = ALU_OR;
            3'b111:  o_dec.alu_op = ALU_AND;
            default: o_dec.illegal = 1'b1;          // SLTU not kept
          endcase
        end else if ((funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
          o_dec.illegal = 1'b0;
          o_dec.alu_op  = ALU_SUB;
        end
      end
      OPC_OPIMM: begin
        o_dec.rs1en   = 1'b1;
        o_dec.rdwen   = 1'b1;
        o_dec.imm_sel = 1'b1;
        o_dec.illegal = 1'b0;
        case (funct3)
          3'b000:  o_dec.alu_op = ALU_ADD;
          3'b100:  o_dec.alu_op = ALU_XOR;
          3'b110:  o_dec.alu_op = ALU_OR;
          3'b111:  o_dec.alu_op = ALU_AND;
          default: o_dec.illegal = 1'b1;            // Shifts and SLTI dropped
        endcase
      end
      OPC_LUI: begin
        o_dec.rdwen   = 1'b1;
        o_dec.imm_sel = 1'b1;
        o_dec.alu_op  = ALU_PASSB;
        o_dec.illegal = 1'b0;
      end
      OPC_LOAD: begin
        o_dec.rs1en   = 1'b1;
        o_dec.rdwen   = 1'b1;
        o_dec.imm_sel = 1'b1;
        o_dec.is_load = 1'b1;
        o_dec.illegal = (funct3 != 3'b010);         // LW only
      end
      default: ;
    endcase

    // Illegal words become a no-op
    if (o_dec.illegal) begin
      o_dec.rs1en   = 1'b0;
      o_dec.rs2en   = 1'b0;
      o_dec.rdwen   = 1'b0;
      o_dec.imm_sel = 1'b0;
      o_dec.is_load = 1'b0;
    end
  end

  assign o_imm = (opcode == OPC_LUI) ? {i_ir[31:12], 12'b0} : {{20{i_ir[31]}}, i_ir[31:20]};

endmodule

`default_nettype wire

//--- source/exu_disp.sv
// Dispatch with OITF hazard stall, operand select and input handshake
`timescale 1ns/1ps
`default_nettype none

module exu_disp import exu_pkg::*; (
  input  wire logic            i_valid,
  output      logic            o_ready,
  input  wire dec_info_t       i_dec,
  input  wire logic [XLEN-1:0] i_imm,
  input  wire logic [XLEN-1:0] i_rs1,
  input  wire logic [XLEN-1:0] i_rs2,
  input  wire logic            i_oitf_full,
  input  wire logic [2:0]      i_oitf_match,      // {rd, rs2, rs1}
  output      logic            o_alu_valid,
  input  wire logic            i_alu_ready,
  output      alu_req_t        o_alu_req,
  output      logic            o_ilegl
);

  logic dep_hit;
  logic hazard;

  // RAW on either source and WAW on the destination
  assign dep_hit = (i_oitf_match[0] & i_dec.rs1en)
                 | (i_oitf_match[1] & i_dec.rs2en)
                 | (i_oitf_match[2] & i_dec.rdwen);
  assign hazard  = dep_hit | (i_dec.is_load & i_oitf_full);

  // Illegal words are swallowed without reaching the ALU
  assign o_ready     = ~hazard & (i_dec.illegal | i_alu_ready);
  assign o_alu_valid = i_valid & ~hazard & ~i_dec.illegal;
  assign o_ilegl     = i_valid & i_dec.illegal & o_ready;

  assign o_alu_req.op1     = i_rs1;
  assign o_alu_req.op2     = i_dec.imm_sel ? i_imm : i_rs2;
  assign o_alu_req.rdidx   = i_dec.rdidx;
  assign o_alu_req.rdwen   = i_dec.rdwen;
  assign o_alu_req.is_load = i_dec.is_load;
  assign o_alu_req.alu_op  = i_dec.alu_op;

endmodule

`default_nettype wire

//--- source/exu_alu.sv
// Integer ALU, also forms the load address and hands it to the OITF
`timescale 1ns/1ps
`default_nettype none

module exu_alu import exu_pkg::*; (
  input  wire logic  i_valid,
  output      logic  o_ready,
  input  wire alu_req_t i_req,
  output      wbck_t o_wbck,
  input  wire logic  i_wbck_gnt,
  output      logic  o_oitf_push,
  output      oitf_entry_t o_oitf_entry
);

  logic [XLEN-1:0] res;

  always_comb begin
    case (i_req.alu_op)
      ALU_ADD:   res = i_req.op1 + i_req.op2;     // Also the load address
      ALU_SUB:   res = i_req.op1 - i_req.op2;
      ALU_AND:   res = i_req.op1 & i_req.op2;
      ALU_OR:    res = i_req.op1 | i_req.op2;
      ALU_XOR:   res = i_req.op1 ^ i_req.op2;
      ALU_SLL:   res = i_req.op1 << i_req.op2[4:0];
      ALU_SRL:   res = i_req.op1 >> i_req.op2[4:0];
      ALU_SLT:   res = {{(XLEN-1){1'b0}}, $signed(i_req.op1) < $signed(i_req.op2)};
      ALU_PASSB: res = i_req.op2;
      default:   res = '0;
    endcase
  end

  // OITF room is checked in dispatch, so loads never wait here
  assign o_ready = i_req.is_load | i_wbck_gnt;

  assign o_wbck.vld   = i_valid & ~i_req.is_load & i_req.rdwen;
  assign o_wbck.rdidx = i_req.rdidx;
  assign o_wbck.data  = res;

  assign o_oitf_push        = i_valid & i_req.is_load;
  assign o_oitf_entry.rdidx = i_req.rdidx;
  assign o_oitf_entry.addr  = res;

endmodule

`default_nettype wire

//--- lsu/exu_oitf.sv
// Outstanding-instruction FIFO of loads, with destination match for hazards
`timescale 1ns/1ps
`default_nettype none

module exu_oitf import exu_pkg::*; (
  input  wire logic               clk,
  input  wire logic               i_arst_n,
  input  wire logic               i_push,
  input  wire oitf_entry_t        i_entry,
  input  wire logic               i_pop,
  output      oitf_entry_t        o_head,
  output      logic               o_head_vld,
  output      logic               o_full,
  output      logic               o_empty,
  input  wire logic [RFIDX_W-1:0] i_rs1idx,
  input  wire logic [RFIDX_W-1:0] i_rs2idx,
  input  wire logic [RFIDX_W-1:0] i_rdidx,
  output      logic [2:0]         o_match
);

  oitf_entry_t           ent_q [OITF_DEPTH];
  logic [OITF_DEPTH-1:0] vld_q;
  logic [ITAG_W-1:0]     wptr_q;
  logic [ITAG_W-1:0]     rptr_q;

  //////////////////////////////////////////////////////////////
  // Pointers and valid bits
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      vld_q  <= '0;
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (i_push) begin
        vld_q[wptr_q] <= 1'b1;
        wptr_q        <= (wptr_q == ITAG_W'(OITF_DEPTH-1)) ? '0 : wptr_q + 1'b1;
      end
      if (i_pop) begin
        vld_q[rptr_q] <= 1'b0;
        rptr_q        <= (rptr_q == ITAG_W'(OITF_DEPTH-1)) ? '0 : rptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) begin
      ent_q[wptr_q] <= i_entry;
    end
  end

  assign o_head     = ent_q[rptr_q];
  assign o_head_vld = vld_q[rptr_q];
  assign o_full     = &vld_q;
  assign o_empty    = ~|vld_q;

  // x0 targets never create a dependency
  always_comb begin
    o_match = '0;
    for (int i = 0; i < OITF_DEPTH; i++) begin
      if (vld_q[i] && (ent_q[i].rdidx != '0)) begin
        o_match[0] = o_match[0] | (ent_q[i].rdidx == i_rs1idx);
        o_match[1] = o_match[1] | (ent_q[i].rdidx == i_rs2idx);
        o_match[2] = o_match[2] | (ent_q[i].rdidx == i_rdidx);
      end
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!i_arst_n) i_push |-> !o_full)
    else $error("OITF push while full");
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_arst_n) i_pop |-> !o_empty)
    else $error("OITF pop while empty");

endmodule

`default_nettype wire

//--- lsu/exu_lsu.sv
// Wishbone classic read master serving the OITF head, long-pipe write-back
`timescale 1ns/1ps
`default_nettype none

module exu_lsu import exu_pkg::*; (
  input  wire logic        clk,
  input  wire logic        i_arst_n,
  input  wire oitf_entry_t i_head,
  input  wire logic        i_head_vld,
  output      logic        o_pop,
  output      wb_req_t     o_wb_req,
  input  wire wb_rsp_t     i_wb_rsp,
  output      wbck_t       o_longp
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } lsu_st_e;

  lsu_st_e st_q;
  logic    done;

  assign done = (st_q == ST_BUSY) & i_wb_rsp.ack;

  //////////////////////////////////////////////////////////////
  // Bus cycle FSM
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      st_q <= ST_IDLE;
    end else begin
      case (st_q)
        ST_IDLE: if (i_head_vld) st_q <= ST_BUSY;
        ST_BUSY: if (i_wb_rsp.ack) st_q <= ST_IDLE;   // At least one idle cycle between
        default: st_q <= ST_IDLE;
      endcase
    end
  end

  // Head entry stays put until it is popped on ack
  assign o_wb_req.cyc = (st_q == ST_BUSY);
  assign o_wb_req.stb = (st_q == ST_BUSY);
  assign o_wb_req.adr = i_head.addr;

  assign o_pop         = done;
  assign o_longp.vld   = done;
  assign o_longp.rdidx = i_head.rdidx;
  assign o_longp.data  = i_wb_rsp.dat;

  a_adr_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_wb_req.stb && !i_wb_rsp.ack) |=> (o_wb_req.stb && $stable(o_wb_req.adr)))
    else $error("Wishbone request changed before ack");

endmodule

`default_nettype wire

//--- source/exu_wbck.sv
// Final write-back arbiter, long-pipe results win over the ALU
`timescale 1ns/1ps
`default_nettype none

module exu_wbck import exu_pkg::*; (
  input  wire wbck_t i_longp,
  input  wire wbck_t i_alu,
  output      logic  o_alu_gnt,
  output      wbck_t o_rf_wbck
);

  // Long-pipe write is never back-pressured
  assign o_alu_gnt = ~i_longp.vld;

  always_comb begin
    if (i_longp.vld) begin
      o_rf_wbck = i_longp;
    end else begin
      o_rf_wbck = i_alu;
    end
  end

endmodule

`default_nettype wire

//--- source/exu_top.sv
// Integer execution stage, connects decode, dispatch, ALU, OITF, LSU and write-back
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; (
  input  wire logic            clk,
  input  wire logic            i_arst_n,
  input  wire logic            i_valid,
  output      logic            o_ready,
  input  wire logic [XLEN-1:0] i_ir,
  output      logic            o_ilegl,
  output      wb_req_t         o_wb_req,
  input  wire wb_rsp_t         i_wb_rsp,
  output      logic [XLEN-1:0] o_rf_rs1,
  output      logic [XLEN-1:0] o_rf_x1,
  output      logic            o_oitf_empty,
  output      logic            o_exu_active
);

  dec_info_t       dec;
  logic [XLEN-1:0] dec_imm;
  logic [XLEN-1:0] rf_rs2;
  wbck_t           rf_wbck;
  logic            alu_valid;
  logic            alu_ready;
  alu_req_t        alu_req;
  wbck_t           alu_wbck;
  logic            alu_gnt;
  logic            oitf_push;
  oitf_entry_t     oitf_in;
  oitf_entry_t     oitf_head;
  logic            oitf_head_vld;
  logic            oitf_pop;
  logic            oitf_full;
  logic [2:0]      oitf_match;
  wbck_t           longp;

  //////////////////////////////////////////////////////////////
  // Decode and operand read
  exu_decode u_exu_decode (.i_ir(i_ir), .o_dec(dec), .o_imm(dec_imm));

  exu_regfile u_exu_regfile (
    .clk(clk), .i_arst_n(i_arst_n), .i_rs1idx(dec.rs1idx), .i_rs2idx(dec.rs2idx),
    .o_rs1(o_rf_rs1), .o_rs2(rf_rs2), .i_wbck(rf_wbck), .o_x1(o_rf_x1)
  );

  exu_disp u_exu_disp (
    .i_valid(i_valid), .o_ready(o_ready), .i_dec(dec), .i_imm(dec_imm),
    .i_rs1(o_rf_rs1), .i_rs2(rf_rs2), .i_oitf_full(oitf_full), .i_oitf_match(oitf_match),
    .o_alu_valid(alu_valid), .i_alu_ready(alu_ready), .o_alu_req(alu_req), .o_ilegl(o_ilegl)
  );

  exu_alu u_exu_alu (
    .i_valid(alu_valid), .o_ready(alu_ready), .i_req(alu_req), .o_wbck(alu_wbck),
    .i_wbck_gnt(alu_gnt), .o_oitf_push(oitf_push), .o_oitf_entry(oitf_in)
  );

  //////////////////////////////////////////////////////////////
  // Long pipe for loads
  exu_oitf u_exu_oitf (
    .clk(clk), .i_arst_n(i_arst_n), .i_push(oitf_push), .i_entry(oitf_in),
    .i_pop(oitf_pop), .o_head(oitf_head), .o_head_vld(oitf_head_vld), .o_full(oitf_full),
    .o_empty(o_oitf_empty), .i_rs1idx(dec.rs1idx), .i_rs2idx(dec.rs2idx),
    .i_rdidx(dec.rdidx), .o_match(oitf_match)
  );

  exu_lsu u_exu_lsu (
    .clk(clk), .i_arst_n(i_arst_n), .i_head(oitf_head), .i_head_vld(oitf_head_vld),
    .o_pop(oitf_pop), .o_wb_req(o_wb_req), .i_wb_rsp(i_wb_rsp), .o_longp(longp)
  );

  exu_wbck u_exu_wbck (
    .i_longp(longp), .i_alu(alu_wbck), .o_alu_gnt(alu_gnt), .o_rf_wbck(rf_wbck)
  );

  assign o_exu_active = ~o_oitf_empty | i_valid;

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
// Testbench clock and reset source, 20 ns clock with reset held for 4 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic o_clk,
  output logic o_arst_n
);

  localparam int HALF_NS    = 10;
  localparam int RST_CYCLES = 4;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);                               // Release away from the active edge
    o_arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/tb_exu.sv
// Directed testbench of the execution stage with a Wishbone memory and shadow registers
`timescale 1ns/1ps
`default_nettype none

module tb_exu import exu_pkg::*; ();

  localparam int NUM_TESTS    = 6;
  localparam int TEST_MAX_CYC = 300;
  localparam int TIMEOUT_CYC  = NUM_TESTS * TEST_MAX_CYC + 200;

  logic            clk;
  logic            arst_n;
  logic            valid;
  logic [XLEN-1:0] ir;
  logic            ready;
  logic            ilegl;
  wb_req_t         wb_req;
  wb_rsp_t         wb_rsp = '0;
  logic [XLEN-1:0] rf_rs1;
  logic [XLEN-1:0] rf_x1;
  logic            oitf_empty;
  logic            exu_active;

  logic [XLEN-1:0] model_rf [32];                  // Architectural register shadow
  logic [XLEN-1:0] ack_adr_q [$];                  // Read addresses in ack order
  logic            ack_hold = 1'b0;
  logic            in_cyc   = 1'b0;
  logic [1:0]      wait_cnt = '0;
  integer          seed     = 63;
  int              cycles   = 0;
  int              err_cnt  = 0;
  int              tests_run    = 0;
  int              tests_failed = 0;

  tb_clkgen u_tb_clkgen (.o_clk(clk), .o_arst_n(arst_n));

  exu_top u_exu_top (
    .clk(clk), .i_arst_n(arst_n), .i_valid(valid), .o_ready(ready), .i_ir(ir),
    .o_ilegl(ilegl), .o_wb_req(wb_req), .i_wb_rsp(wb_rsp), .o_rf_rs1(rf_rs1),
    .o_rf_x1(rf_x1), .o_oitf_empty(oitf_empty), .o_exu_active(exu_active)
  );

  ////////////////////////////////////////////////////////////
  // Wishbone memory returning the inverted address
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_rsp   <= '0;
      in_cyc   <= 1'b0;
      wait_cnt <= '0;
    end else begin
      wb_rsp.ack <= 1'b0;
      if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
        if (!in_cyc) begin
          in_cyc   <= 1'b1;
          wait_cnt <= 2'($unsigned($random(seed)) % 4);   // 0 to 3 extra cycles
        end else if (wait_cnt != '0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else if (!ack_hold) begin
          wb_rsp.ack <= 1'b1;
          wb_rsp.dat <= ~wb_req.adr;
          in_cyc     <= 1'b0;
          ack_adr_q.push_back(wb_req.adr);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Encoders and the reference ALU
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] rr_result(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b101:  return a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("error: %s", what);
      err_cnt++;
    end
  endtask

  // Present one word and hold it until the accept edge
  task automatic issue(input logic [31:0] word, input logic exp_ilegl);
    logic accepted;
    accepted = 1'b0;
    valid <= 1'b1;
    ir    <= word;
    while (!accepted) begin
      @(negedge clk);
      accepted = ready;
    end
    expect_true(ilegl == exp_ilegl, exp_ilegl ? "o_ilegl low on an illegal word"
                                              : "o_ilegl high on a legal word");
    expect_true(exu_active, "o_exu_active low with an instruction presented");
    @(posedge clk);
    valid <= 1'b0;
  endtask

  task automatic hold_stalled(input logic [31:0] word, input int n, input string what);
    valid <= 1'b1;
    ir    <= word;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      expect_true(!ready, what);
      @(posedge clk);
    end
    valid <= 1'b0;
  endtask

  task automatic compare_reg(input int idx);
    ir <= {12'h000, 5'(idx), 3'b000, 5'd0, OPC_OPIMM};    // Read through rs1 with valid low
    @(negedge clk);
    expect_eq($sformatf("x%0d", idx), rf_rs1, model_rf[idx]);
    @(posedge clk);
  endtask

  task automatic compare_all_regs();
    for (int r = 0; r < 32; r++) begin
      compare_reg(r);
    end
  endtask

  task automatic exec_rr(input logic [2:0] f3, input logic sub, input int rd, input int rs1,
                         input int rs2);
    logic [31:0] exp;
    exp = rr_result(f3, sub, model_rf[rs1], model_rf[rs2]);
    issue(enc_r(sub ? 7'h20 : 7'h00, 5'(rs2), 5'(rs1), f3, 5'(rd)), 1'b0);
    if (rd != 0) begin
      model_rf[rd] = exp;
    end
  endtask

  task automatic exec_imm(input logic [2:0] f3, input int rd, input int rs1,
                          input logic [11:0] imm);
    logic [31:0] exp;
    exp = rr_result(f3, 1'b0, model_rf[rs1], sext12(imm));
    issue(enc_i(imm, 5'(rs1), f3, 5'(rd), OPC_OPIMM), 1'b0);
    if (rd != 0) begin
      model_rf[rd] = exp;
    end
  endtask

  task automatic exec_lui(input int rd, input logic [19:0] imm);
    issue({imm, 5'(rd), OPC_LUI}, 1'b0);
    if (rd != 0) begin
      model_rf[rd] = {imm, 12'h000};
    end
  endtask

  task automatic exec_load(input int rd, input int rs1, input logic [11:0] imm,
                           output logic [31:0] addr);
    addr = model_rf[rs1] + sext12(imm);
    issue(enc_i(imm, 5'(rs1), 3'b010, 5'(rd), OPC_LOAD), 1'b0);
    model_rf[rd] = ~addr;
  endtask

  task automatic set_reg(input int rd, input logic [31:0] v);
    logic [19:0] upper;
    upper = v[31:12] + 20'(v[11]);                  // Undo the sign of the low part
    exec_lui(rd, upper);
    exec_imm(3'b000, rd, rd, v[11:0]);
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (!oitf_empty) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests_run++;
    if (err_cnt != errs_at_start) begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", name, err_cnt - errs_at_start);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  task automatic run_reg_ops();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = err_cnt;
    compare_all_regs();                             // Zero out of reset
    expect_true(!wb_req.cyc && oitf_empty && !ilegl, "bus, OITF or o_ilegl busy after reset");
    a = $random(seed);
    b = $random(seed);
    set_reg(5, a);
    set_reg(6, b);
    exec_rr(3'b000, 1'b0, 10, 5, 6);
    exec_rr(3'b000, 1'b1, 11, 5, 6);
    exec_rr(3'b111, 1'b0, 12, 5, 6);
    exec_rr(3'b110, 1'b0, 13, 5, 6);
    exec_rr(3'b100, 1'b0, 14, 5, 6);
    exec_rr(3'b001, 1'b0, 15, 5, 6);
    exec_rr(3'b101, 1'b0, 16, 5, 6);
    exec_rr(3'b010, 1'b0, 17, 5, 6);
    for (int r = 5; r <= 17; r++) begin
      compare_reg(r);
    end
    end_test("reg_reg_ops", errs);
  endtask

  task automatic imm_and_lui();
    int errs;
    errs = err_cnt;
    exec_imm(3'b000, 1, 0, 12'hFFB);                // x1 = -5
    @(negedge clk);
    expect_eq("o_rf_x1", rf_x1, model_rf[1]);
    @(posedge clk);
    exec_imm(3'b111, 7, 5, 12'h0F0);
    exec_imm(3'b110, 8, 5, 12'h800);
    exec_imm(3'b100, 9, 5, 12'hFFF);
    exec_lui(11, 20'hABCDE);
    exec_imm(3'b000, 0, 5, 12'h07B);                // Discarded by x0
    exec_lui(0, 20'h12345);
    compare_reg(0);
    compare_reg(1);
    for (int r = 7; r <= 11; r++) begin
      compare_reg(r);
    end
    end_test("imm_and_lui", errs);
  endtask

  task automatic single_load();
    int          errs;
    logic [31:0] addr;
    errs = err_cnt;
    ack_hold <= 1'b1;
    set_reg(12, 32'h0000_0100);
    exec_load(13, 12, 12'h008, addr);
    @(negedge clk);
    expect_true(!wb_req.cyc, "Wishbone cycle started on the accept cycle");
    expect_true(!oitf_empty, "o_oitf_empty high with a load outstanding");
    expect_true(exu_active, "o_exu_active low with a load outstanding");
    @(posedge clk);
    @(negedge clk);
    expect_true(wb_req.cyc && wb_req.stb, "no Wishbone cycle one cycle after accept");
    expect_eq("o_wb_req.adr", wb_req.adr, addr);
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      expect_true(!oitf_empty, "o_oitf_empty high before the ack");
    end
    @(posedge clk);
    ack_hold <= 1'b0;
    wait_idle();
    compare_reg(13);
    @(negedge clk);
    expect_true(oitf_empty && !wb_req.cyc, "OITF or bus still busy after the ack");
    expect_true(!exu_active, "o_exu_active high with no load and no instruction");
    @(posedge clk);
    end_test("single_load", errs);
  endtask

  task automatic load_hazards();
    int          errs;
    logic [31:0] addr;
    errs = err_cnt;
    ack_hold <= 1'b1;
    set_reg(14, 32'h0000_0200);
    exec_load(15, 14, 12'h000, addr);
    hold_stalled(enc_r(7'h00, 5'd5, 5'd15, 3'b000, 5'd16), 4,
                 "dependent ADD accepted while its load is outstanding");
    exec_rr(3'b000, 1'b0, 17, 5, 6);                // Independent ADD overtakes the load
    @(negedge clk);
    expect_true(!oitf_empty, "load finished while the ack was held");
    @(posedge clk);
    ack_hold <= 1'b0;
    exec_rr(3'b000, 1'b0, 16, 15, 5);
    wait_idle();
    for (int r = 14; r <= 17; r++) begin
      compare_reg(r);
    end
    end_test("load_hazards", errs);
  endtask

  task automatic two_loads_in_flight();
    int          errs;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    errs = err_cnt;
    ack_hold <= 1'b1;
    ack_adr_q.delete();
    set_reg(18, 32'h0000_0300);
    exec_load(19, 18, 12'h000, a0);
    exec_load(20, 18, 12'h004, a1);
    hold_stalled(enc_i(12'h008, 5'd18, 3'b010, 5'd21, OPC_LOAD), 4,
                 "third load accepted with the OITF full");
    ack_hold <= 1'b0;
    exec_load(21, 18, 12'h008, a2);
    expect_true(ack_adr_q.size() >= 1, "third load accepted before the first ack");
    wait_idle();
    expect_true(ack_adr_q.size() == 3, "wrong number of Wishbone cycles");
    if (ack_adr_q.size() == 3) begin
      expect_eq("ack 0 adr", ack_adr_q[0], a0);
      expect_eq("ack 1 adr", ack_adr_q[1], a1);
      expect_eq("ack 2 adr", ack_adr_q[2], a2);
    end
    for (int r = 18; r <= 21; r++) begin
      compare_reg(r);
    end
    end_test("two_loads", errs);
  endtask

  task automatic illegal_words();
    int          errs;
    logic [31:0] bad [4];
    errs = err_cnt;
    bad[0] = 32'hFFFF_FFFF;
    bad[1] = enc_r(7'h00, 5'd6, 5'd5, 3'b011, 5'd10);        // SLTU
    bad[2] = enc_i(12'h003, 5'd5, 3'b101, 5'd11, OPC_OPIMM); // Shift immediate
    bad[3] = enc_i(12'h000, 5'd18, 3'b001, 5'd12, OPC_LOAD); // LH
    for (int i = 0; i < 4; i++) begin
      issue(bad[i], 1'b1);
      @(negedge clk);
      expect_true(!ilegl, "o_ilegl held past the accept cycle");
      @(posedge clk);
    end
    expect_true(oitf_empty && !wb_req.cyc, "illegal load reached the OITF or the bus");
    compare_all_regs();
    end_test("illegal_words", errs);
  endtask

  initial begin
    valid = 1'b0;
    ir    = '0;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    wait (arst_n === 1'b1);
    @(posedge clk);
    run_reg_ops();
    imm_and_lui();
    single_load();
    load_hazards();
    two_loads_in_flight();
    illegal_words();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
common/exu_pkg.sv
source/exu_regfile.sv
source/exu_decode.sv
source/exu_disp.sv
source/exu_alu.sv
lsu/exu_oitf.sv
lsu/exu_lsu.sv
source/exu_wbck.sv
source/exu_top.sv
dv/tb_clkgen.sv
dv/tb_exu.sv

//--- Makefile
# Verilator build and run of the execution stage testbench

SIM       ?= verilator
TOP       ?= tb_exu
FILELIST  ?= src.f
FLAGS     ?= --binary --timing --assert -j 0 --top-module $(TOP)
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
